// ==== list.f ====
+incdir+verilog
verilog/rvIsaPkg.sv
verilog/rvPipePkg.sv
verilog/pipeStage.sv
verilog/regFile.sv
verilog/gsharePredictor.sv
verilog/rvController.sv
verilog/hazardUnit.sv
verilog/rvDatapath.sv
verilog/rvCore.sv
test/rvCoreChecker.sv
test/rvCoreTb.sv

// ==== Makefile ====
TOP = rvCoreTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir -o simv

# Pass only if the simulation printed the pass message
run: compile
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== test/rvCoreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvCoreTb import rvPipePkg::*; ();
    localparam int ProgLen = 200;  // Random slots before the final self-loop
    localparam int MaxWait = 5000;

    logic        clk   = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] pcF, instrF, readData;
    dmemReq_t    dmemReq;
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] lfsr = 32'd79;
    logic [31:0] haltPc;
    int          modelStores = 0;
    int          timeouts    = 0;
    int          storesSeen, valueErrors, otherErrors;
    int          waitCycles;

    always #10 clk = ~clk;

    rvCore dut (
        .clk, .reset, .pcF_o(pcF), .instrF_i(instrF), .dmemReq_o(dmemReq),
        .readData_i(readData)
    );

    rvCoreChecker chk (
        .clk, .reset, .req_i(dmemReq), .storesSeen_o(storesSeen),
        .valueErrors_o(valueErrors), .otherErrors_o(otherErrors)
    );

    // Both memories answer in the same cycle
    assign instrF   = imem[pcF[9:2]];
    assign readData = dmem[dmemReq.addr[7:2]];

    always @(negedge clk) begin
        if (!reset && dmemReq.we) begin
            dmem[dmemReq.addr[7:2]] = dmemReq.wdata;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic nextBit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    function automatic logic [4:0] pickReg();
        logic [31:0] v;
        v = randBits(3) % 32'd7 + 32'd1;  // x1 to x7
        return v[4:0];
    endfunction

    // Data memory pattern mixes every address bit
    function automatic logic [31:0] fillWord(input logic [5:0] idx);
        return ({24'd0, idx, 2'd0} * 32'h9E37_79B1) ^ 32'h1234_5678;
    endfunction

    function automatic logic [31:0] encR(input logic sub, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {1'b0, sub, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};  // Base is x0
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic buildProgram();
        logic [31:0] kind, pick, hop;
        logic [2:0]  f3;
        logic [4:0]  src;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < ProgLen; i++) begin
            kind = randBits(3);
            if (i % 12 == 4) begin
                kind = 32'd4;  // Load right before every other store
            end
            hop  = 32'd2 + randBits(3) % 32'd5;  // Forward by 2 to 6 slots
            if (hop > ProgLen - i) begin
                hop = ProgLen - i;  // Never past the self-loop
            end
            if (i % 6 == 5) begin
                pick = randBits(6);
                if (imem[i-1][6:0] == 7'b0000011) begin
                    src = imem[i-1][11:7];  // Store the value just loaded
                end else begin
                    src = pickReg();
                end
                imem[i] = encS({4'd0, pick[5:0], 2'd0}, src);
            end else begin
                case (kind[2:0])
                    3'd0, 3'd1: begin
                        pick = randBits(3) % 32'd5;
                        f3   = pick == 32'd2 ? 3'b111 : pick == 32'd3 ? 3'b110 :
                               pick == 32'd4 ? 3'b010 : 3'b000;
                        imem[i] = encR(pick == 32'd1, pickReg(), pickReg(), f3, pickReg());
                    end
                    3'd2: begin
                        pick    = randBits(12);
                        imem[i] = encI(pick[11:0], pickReg(), 3'b000, pickReg(), 7'b0010011);
                    end
                    3'd3: begin
                        pick    = randBits(20);
                        imem[i] = encU(pick[19:0], pickReg());
                    end
                    3'd4: begin
                        pick    = randBits(6);
                        imem[i] = encI({4'd0, pick[5:0], 2'd0}, 5'd0, 3'b010, pickReg(),
                                       7'b0000011);
                    end
                    3'd5, 3'd6: begin
                        imem[i] = encB({hop[10:0], 2'd0}, pickReg(), pickReg(), {2'd0, kind[0]});
                    end
                    default: imem[i] = encJ({8'd0, hop[10:0], 2'd0}, 5'd1);  // jal x1
                endcase
            end
        end
        imem[ProgLen] = encJ(21'd0, 5'd0);  // Final self-loop
    endtask

    // ISA reference in program order
    task automatic runModel();
        logic [31:0] regs [0:31];
        logic [31:0] mem [0:63];
        logic [31:0] pc, nextPc, ins, a, b, immI, immS, immB, immJ, res, addr;
        logic        writes, halted;
        int          steps;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < 64; w++) begin
            mem[w] = fillWord(w[5:0]);
        end
        pc     = 32'd0;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 4 * ProgLen) begin
            ins    = imem[pc[9:2]];
            a      = regs[ins[19:15]];
            b      = regs[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            nextPc = pc + 32'd4;
            writes = 1'b1;
            res    = '0;
            case (ins[6:0])
                7'b0110011: begin
                    case (ins[14:12])
                        3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        default: res = ins[30] ? a - b : a + b;
                    endcase
                end
                7'b0010011: res = a + immI;
                7'b0000011: begin
                    addr = a + immI;
                    res  = mem[addr[7:2]];
                end
                7'b0100011: begin
                    addr           = a + immS;
                    mem[addr[7:2]] = b;
                    writes         = 1'b0;
                    chk.expectStore(addr, b);
                    modelStores++;
                end
                7'b1100011: begin
                    writes = 1'b0;
                    if ((a == b) != ins[12]) begin  // funct3 bit 0 marks bne
                        nextPc = pc + immB;
                    end
                end
                7'b1101111: begin
                    res    = pc + 32'd4;
                    nextPc = pc + immJ;
                    halted = (immJ == 32'd0);
                end
                7'b0110111: res = {ins[31:12], 12'd0};
                default: writes = 1'b0;
            endcase
            if (writes && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
            pc = nextPc;
            steps++;
        end
        haltPc = pc;
    endtask

    initial begin
        buildProgram();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i[5:0]);
        end
        runModel();
        repeat (3) @(negedge clk);
        reset = 1'b0;

        waitCycles = 0;
        while (storesSeen < modelStores && waitCycles < MaxWait) begin
            @(negedge clk);
            waitCycles++;
        end
        if (storesSeen < modelStores) begin
            $display("Timed out after %0d cycles waiting for stores, %0d of %0d seen",
                     waitCycles, storesSeen, modelStores);
            timeouts++;
        end

        // Core now spins on the self-loop and must not store again
        repeat (30) @(negedge clk);
        chk.checkValue("pcF_o", pcF, haltPc);  // Fetch parks on the self-loop
        repeat (10) @(negedge clk);

        $display("Errors: %0d value mismatches, %0d other, %0d timeouts; %0d of %0d stores",
                 valueErrors, otherErrors, timeouts, storesSeen, modelStores);
        if (valueErrors + otherErrors + timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/rvCoreChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvCoreChecker import rvPipePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  dmemReq_t req_i,
    output int       storesSeen_o,
    output int       valueErrors_o,
    output int       otherErrors_o
);
    logic [31:0] expAddr [$];  // Model stores in program order
    logic [31:0] expData [$];
    int          storesSeen  = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;

    assign storesSeen_o  = storesSeen;
    assign valueErrors_o = valueErrors;
    assign otherErrors_o = otherErrors;

    // Filled by the ISA model before reset is released
    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, want);
            valueErrors++;
        end
    endtask

    // Request comes straight from the Memory stage register, steady by the falling edge
    always @(negedge clk) begin
        logic [31:0] wantAddr;
        logic [31:0] wantData;
        if (req_i.we === 1'b1) begin
            if (reset) begin
                $display("Store strobe raised while reset was held, at time %0t", $time);
                otherErrors++;
            end else if (expAddr.size() == 0) begin
                $display("Store to address %h at time %0t has no matching model store",
                         req_i.addr, $time);
                otherErrors++;
            end else begin
                wantAddr = expAddr.pop_front();
                wantData = expData.pop_front();
                storesSeen++;
                checkValue("dmemReq_o.addr", req_i.addr, wantAddr);
                checkValue("dmemReq_o.wdata", req_i.wdata, wantData);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvCore.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvConsts.svh"

module rvCore import rvIsaPkg::*, rvPipePkg::*; (
    input  logic                clk,
    input  logic                reset,
    output logic [`RV_XLEN-1:0] pcF_o,
    input  logic [`RV_XLEN-1:0] instrF_i,
    output dmemReq_t            dmemReq_o,
    input  logic [`RV_XLEN-1:0] readData_i
);
    ctrl_t      ctrlD;
    immKind_t   immKindD;
    fwdSel_t    fwdA, fwdB;
    logic       stallF, stallD, flushD, flushE, mispredict, isLoadE;
    logic       regWriteM, regWriteW, funct7b5D;
    logic [4:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    logic [6:0] opcodeD;
    logic [2:0] funct3D;

    rvDatapath dp (
        .clk, .reset, .instrF_i, .pcF_o, .readData_i, .dmemReq_o,
        .ctrlD_i(ctrlD), .immKind_i(immKindD),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD), .flushE_i(flushE),
        .fwdA_i(fwdA), .fwdB_i(fwdB),
        .rs1D_o(rs1D), .rs2D_o(rs2D), .rs1E_o(rs1E), .rs2E_o(rs2E),
        .rdE_o(rdE), .rdM_o(rdM), .rdW_o(rdW),
        .regWriteM_o(regWriteM), .regWriteW_o(regWriteW),
        .opcodeD_o(opcodeD), .funct3D_o(funct3D), .funct7b5D_o(funct7b5D),
        .mispredict_o(mispredict)
    );

    rvController ctrl (
        .clk, .reset, .opcode_i(opcodeD), .funct3_i(funct3D), .funct7b5_i(funct7b5D),
        .flushE_i(flushE), .ctrlD_o(ctrlD), .immKind_o(immKindD), .isLoadE_o(isLoadE)
    );

    hazardUnit hz (
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW),
        .regWriteM_i(regWriteM), .regWriteW_i(regWriteW),
        .isLoadE_i(isLoadE), .mispredict_i(mispredict),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
        .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

endmodule

`default_nettype wire

// ==== verilog/rvDatapath.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvConsts.svh"

module rvDatapath import rvIsaPkg::*, rvPipePkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [`RV_XLEN-1:0] instrF_i,
    output logic [`RV_XLEN-1:0] pcF_o,
    input  logic [`RV_XLEN-1:0] readData_i,
    output dmemReq_t            dmemReq_o,
    input  ctrl_t               ctrlD_i,
    input  immKind_t            immKind_i,
    input  logic                stallF_i,
    input  logic                stallD_i,
    input  logic                flushD_i,
    input  logic                flushE_i,
    input  fwdSel_t             fwdA_i,
    input  fwdSel_t             fwdB_i,
    output logic [4:0]          rs1D_o,
    output logic [4:0]          rs2D_o,
    output logic [4:0]          rs1E_o,
    output logic [4:0]          rs2E_o,
    output logic [4:0]          rdE_o,
    output logic [4:0]          rdM_o,
    output logic [4:0]          rdW_o,
    output logic                regWriteM_o,
    output logic                regWriteW_o,
    output logic [6:0]          opcodeD_o,
    output logic [2:0]          funct3D_o,
    output logic                funct7b5D_o,
    output logic                mispredict_o
);
    fetchDecode_t           fetchF, fetchD;
    decodeExec_t            decodeD, decodeE;
    execMem_t               execE, execM;
    memWb_t                 memM, memW;
    bpUpdate_t              bpUpd;
    logic                   predTakenF, takenE;
    logic [`RV_BP_BITS-1:0] phtIdxF;
    logic [`RV_XLEN-1:0]    predTargetF, pcPlus4F, redirectE, instrD, immD, rd1D, rd2D;
    logic [`RV_XLEN-1:0]    srcAE, fwdBE, srcBE, aluE, targetE, resultM, resultW;

    // Fetch
    gsharePredictor bp (
        .clk, .reset, .pc_i(pcF_o), .predTaken_o(predTakenF),
        .predTarget_o(predTargetF), .phtIdx_o(phtIdxF), .upd_i(bpUpd)
    );

    assign pcPlus4F = pcF_o + `RV_XLEN'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `RV_RESET_PC;
        end else if (mispredict_o) begin
            pcF_o <= redirectE;  // Execute redirect beats prediction
        end else if (!stallF_i) begin
            pcF_o <= predTakenF ? predTargetF : pcPlus4F;
        end
    end

    assign fetchF = '{instr: instrF_i, pc: pcF_o, pcPlus4: pcPlus4F,
                      phtIdx: phtIdxF, predTaken: predTakenF};

    pipeStage #(.payload_t(fetchDecode_t)) stageFD (
        .clk, .reset, .stall_i(stallD_i), .flush_i(flushD_i), .d_i(fetchF), .q_o(fetchD)
    );

    // Decode
    assign instrD      = fetchD.instr;
    assign opcodeD_o   = instrD[6:0];
    assign funct3D_o   = instrD[14:12];
    assign funct7b5D_o = instrD[30];
    assign rs1D_o      = instrD[19:15];
    assign rs2D_o      = instrD[24:20];

    regFile rf (
        .clk, .rs1_i(rs1D_o), .rs2_i(rs2D_o), .rd_i(memW.rd), .we_i(memW.ctrl.regWrite),
        .wd_i(resultW), .rd1_o(rd1D), .rd2_o(rd2D)
    );

    always_comb begin
        case (immKind_i)
            IMM_S:   immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            IMM_B:   immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            IMM_J:   immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            IMM_U:   immD = {instrD[31:12], 12'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};  // I format
        endcase
    end

    assign decodeD = '{rd1: rd1D, rd2: rd2D, pc: fetchD.pc, pcPlus4: fetchD.pcPlus4,
                       imm: immD, rs1: rs1D_o, rs2: rs2D_o, rd: instrD[11:7],
                       phtIdx: fetchD.phtIdx, predTaken: fetchD.predTaken, ctrl: ctrlD_i};

    pipeStage #(.payload_t(decodeExec_t)) stageDE (
        .clk, .reset, .stall_i(1'b0), .flush_i(flushE_i), .d_i(decodeD), .q_o(decodeE)
    );

    // Execute
    assign rs1E_o = decodeE.rs1;
    assign rs2E_o = decodeE.rs2;
    assign rdE_o  = decodeE.rd;

    always_comb begin
        case (fwdA_i)
            FWD_MEM: srcAE = resultM;
            FWD_WB:  srcAE = resultW;
            default: srcAE = decodeE.rd1;
        endcase
        case (fwdB_i)
            FWD_MEM: fwdBE = resultM;
            FWD_WB:  fwdBE = resultW;
            default: fwdBE = decodeE.rd2;
        endcase
    end

    assign srcBE = decodeE.ctrl.aluSrcImm ? decodeE.imm : fwdBE;

    always_comb begin
        case (decodeE.ctrl.aluOp)
            ALU_SUB: aluE = srcAE - srcBE;
            ALU_AND: aluE = srcAE & srcBE;
            ALU_OR:  aluE = srcAE | srcBE;
            ALU_SLT: aluE = {{(`RV_XLEN-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
            default: aluE = srcAE + srcBE;
        endcase
    end

    assign targetE   = decodeE.pc + decodeE.imm;
    assign takenE    = decodeE.ctrl.isJal ||
                       (decodeE.ctrl.isBranch && ((srcAE == fwdBE) != decodeE.ctrl.branchNe));
    assign redirectE = takenE ? targetE : decodeE.pcPlus4;

    // Decode holds whatever fetch chose after this instruction
    assign mispredict_o = decodeE.predTaken ? (!takenE || fetchD.pc != targetE) : takenE;

    assign bpUpd = '{phtWe: decodeE.ctrl.isBranch, taken: takenE, phtIdx: decodeE.phtIdx,
                     ghrRestore: mispredict_o,
                     btbWe: decodeE.ctrl.isBranch || decodeE.ctrl.isJal,
                     btbIdx: decodeE.pc[`RV_BP_BITS+1:2], target: targetE};

    assign execE = '{aluResult: aluE, writeData: fwdBE, pcPlus4: decodeE.pcPlus4,
                     imm: decodeE.imm, rd: decodeE.rd, ctrl: decodeE.ctrl};

    pipeStage #(.payload_t(execMem_t)) stageEM (
        .clk, .reset, .stall_i(1'b0), .flush_i(1'b0), .d_i(execE), .q_o(execM)
    );

    // Memory
    assign rdM_o       = execM.rd;
    assign regWriteM_o = execM.ctrl.regWrite;
    assign resultM     = (execM.ctrl.resultSel == RES_PC4) ? execM.pcPlus4 :
                         (execM.ctrl.resultSel == RES_IMM) ? execM.imm : execM.aluResult;
    assign dmemReq_o   = '{we: execM.ctrl.memWrite, addr: execM.aluResult,
                           wdata: execM.writeData};

    // Load-use stall keeps a load in Memory off the forwarding path
    aNoLoadFwd: assert property (@(posedge clk) disable iff (reset)
        execM.ctrl.resultSel == RES_MEM |-> fwdA_i != FWD_MEM && fwdB_i != FWD_MEM);

    assign memM = '{aluResult: execM.aluResult, writeData: execM.writeData,
                    pcPlus4: execM.pcPlus4, imm: execM.imm, rd: execM.rd,
                    ctrl: execM.ctrl, readData: readData_i};

    pipeStage #(.payload_t(memWb_t)) stageMW (
        .clk, .reset, .stall_i(1'b0), .flush_i(1'b0), .d_i(memM), .q_o(memW)
    );

    // Writeback
    assign rdW_o       = memW.rd;
    assign regWriteW_o = memW.ctrl.regWrite;

    always_comb begin
        case (memW.ctrl.resultSel)
            RES_ALU: resultW = memW.aluResult;
            RES_MEM: resultW = memW.readData;
            RES_PC4: resultW = memW.pcPlus4;
            RES_IMM: resultW = memW.imm;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import rvIsaPkg::*; (
    input  logic [4:0] rs1D_i,
    input  logic [4:0] rs2D_i,
    input  logic [4:0] rs1E_i,
    input  logic [4:0] rs2E_i,
    input  logic [4:0] rdE_i,
    input  logic [4:0] rdM_i,
    input  logic [4:0] rdW_i,
    input  logic       regWriteM_i,
    input  logic       regWriteW_i,
    input  logic       isLoadE_i,
    input  logic       mispredict_i,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o,
    output fwdSel_t    fwdA_o,
    output fwdSel_t    fwdB_o
);
    logic loadUse;

    // Memory is younger than Writeback, so it wins
    function automatic fwdSel_t pickFwd(input logic [4:0] rs, input logic [4:0] rdM,
                                        input logic weM, input logic [4:0] rdW,
                                        input logic weW);
        if (rs != 5'd0 && weM && rs == rdM) return FWD_MEM;
        if (rs != 5'd0 && weW && rs == rdW) return FWD_WB;
        return FWD_RF;
    endfunction

    assign fwdA_o = pickFwd(rs1E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);
    assign fwdB_o = pickFwd(rs2E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);

    assign loadUse = isLoadE_i && rdE_i != 5'd0 && (rdE_i == rs1D_i || rdE_i == rs2D_i);

    // A redirect discards Decode, so holding it is pointless
    assign stallF_o = loadUse && !mispredict_i;
    assign stallD_o = loadUse && !mispredict_i;
    assign flushD_o = mispredict_i;
    assign flushE_o = loadUse || mispredict_i;

endmodule

`default_nettype wire

// ==== verilog/rvController.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvController import rvIsaPkg::*, rvPipePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] opcode_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7b5_i,
    input  logic       flushE_i,
    output ctrl_t      ctrlD_o,
    output immKind_t   immKind_o,
    output logic       isLoadE_o
);
    logic   isLoadD;
    aluOp_t aluOpD;

    // ALU decoder; funct7 bit 5 selects sub only for register ops
    always_comb begin
        case (funct3_i)
            F3_ADD:  aluOpD = (opcode_i == OP_REG && funct7b5_i) ? ALU_SUB : ALU_ADD;
            F3_SLT:  aluOpD = ALU_SLT;
            F3_OR:   aluOpD = ALU_OR;
            F3_AND:  aluOpD = ALU_AND;
            default: aluOpD = ALU_ADD;
        endcase
    end

    // Main decoder
    always_comb begin
        ctrlD_o   = '0;
        immKind_o = IMM_I;
        isLoadD   = 1'b0;
        case (opcode_i)
            OP_REG: begin
                ctrlD_o.regWrite = 1'b1;
                ctrlD_o.aluOp    = aluOpD;
            end
            OP_IMM: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;
                ctrlD_o.aluOp     = aluOpD;
            end
            OP_LOAD: if (funct3_i == F3_WORD) begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;
                ctrlD_o.resultSel = RES_MEM;
                isLoadD           = 1'b1;
            end
            OP_STORE: if (funct3_i == F3_WORD) begin
                ctrlD_o.memWrite  = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;
                immKind_o         = IMM_S;
            end
            OP_BRANCH: if (funct3_i == F3_BEQ || funct3_i == F3_BNE) begin
                ctrlD_o.isBranch = 1'b1;
                ctrlD_o.branchNe = (funct3_i == F3_BNE);
                immKind_o        = IMM_B;
            end
            OP_JAL: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.isJal     = 1'b1;
                ctrlD_o.resultSel = RES_PC4;  // Link value
                immKind_o         = IMM_J;
            end
            OP_LUI: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.resultSel = RES_IMM;
                immKind_o         = IMM_U;
            end
            default: ctrlD_o = '0;  // Unknown stays inert
        endcase
    end

    // Execute-stage load flag for the hazard unit
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            isLoadE_o <= 1'b0;
        end else begin
            isLoadE_o <= isLoadD;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gsharePredictor.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvConsts.svh"

module gsharePredictor import rvPipePkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`RV_XLEN-1:0]    pc_i,
    output logic                   predTaken_o,
    output logic [`RV_XLEN-1:0]    predTarget_o,
    output logic [`RV_BP_BITS-1:0] phtIdx_o,
    input  bpUpdate_t              upd_i
);
    localparam int Entries = 1 << `RV_BP_BITS;

    logic [1:0]                pht [Entries];
    logic [`RV_BP_BITS-1:0]    ghr;
    logic [`RV_XLEN-1:0]       btbTarget [Entries];
    logic [Entries-1:0]        btbValid;
    logic [Entries-1:0]        btbJal;  // Entry holds a jal, taken regardless of PHT
    logic [`RV_BP_BITS-1:0]    btbIdxF;

    assign btbIdxF      = pc_i[`RV_BP_BITS+1:2];
    assign phtIdx_o     = btbIdxF ^ ghr;
    assign predTarget_o = btbTarget[btbIdxF];
    assign predTaken_o  = btbValid[btbIdxF] && (btbJal[btbIdxF] || pht[phtIdx_o][1]);

    // Saturating 2-bit counters, start weakly not taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < Entries; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (upd_i.phtWe) begin
            if (upd_i.taken && pht[upd_i.phtIdx] != 2'b11) begin
                pht[upd_i.phtIdx] <= pht[upd_i.phtIdx] + 2'd1;
            end else if (!upd_i.taken && pht[upd_i.phtIdx] != 2'b00) begin
                pht[upd_i.phtIdx] <= pht[upd_i.phtIdx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || upd_i.ghrRestore) begin
            ghr <= '0;
        end else if (upd_i.phtWe) begin
            ghr <= {ghr[`RV_BP_BITS-2:0], upd_i.taken};  // Newest outcome in bit 0
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            btbValid <= '0;
        end else if (upd_i.btbWe) begin
            btbValid[upd_i.btbIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_i.btbWe) begin
            btbTarget[upd_i.btbIdx] <= upd_i.target;
            btbJal[upd_i.btbIdx]    <= !upd_i.phtWe;  // Only branches train the PHT
        end
    end

    // Word-aligned targets only, else fetch would go off the instruction grid
    aBtbAligned: assert property (@(posedge clk) disable iff (reset)
        upd_i.btbWe |-> upd_i.target[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvConsts.svh"

module regFile (
    input  logic                clk,
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    input  logic [4:0]          rd_i,
    input  logic                we_i,
    input  logic [`RV_XLEN-1:0] wd_i,
    output logic [`RV_XLEN-1:0] rd1_o,
    output logic [`RV_XLEN-1:0] rd2_o
);
    logic [`RV_XLEN-1:0] regs [1:31];  // x0 has no storage

    // Falling edge write, so Decode reads see this cycle's Writeback
    always_ff @(negedge clk) begin
        if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rd2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== verilog/pipeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeStage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // Zero payload is a bubble with inactive controls
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvPipePkg.sv ====
`default_nettype none
`include "rvConsts.svh"

package rvPipePkg;
    import rvIsaPkg::*;

    // Decoded controls, all zero is a bubble
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        resultSel_t resultSel;
        logic       aluSrcImm;
        aluOp_t     aluOp;
        logic       isBranch;
        logic       isJal;
        logic       branchNe;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]    instr;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    pcPlus4;
        logic [`RV_BP_BITS-1:0] phtIdx;
        logic                   predTaken;
    } fetchDecode_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]    rd1;
        logic [`RV_XLEN-1:0]    rd2;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_XLEN-1:0]    pcPlus4;
        logic [`RV_XLEN-1:0]    imm;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [4:0]             rd;
        logic [`RV_BP_BITS-1:0] phtIdx;
        logic                   predTaken;
        ctrl_t                  ctrl;
    } decodeExec_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] aluResult;
        logic [`RV_XLEN-1:0] writeData;
        logic [`RV_XLEN-1:0] pcPlus4;
        logic [`RV_XLEN-1:0] imm;
        logic [4:0]          rd;
        ctrl_t               ctrl;
    } execMem_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] aluResult;
        logic [`RV_XLEN-1:0] writeData;
        logic [`RV_XLEN-1:0] pcPlus4;
        logic [`RV_XLEN-1:0] imm;
        logic [4:0]          rd;
        ctrl_t               ctrl;
        logic [`RV_XLEN-1:0] readData;
    } memWb_t;

    // Predictor training from Execute
    typedef struct packed {
        logic                   phtWe;
        logic                   taken;
        logic [`RV_BP_BITS-1:0] phtIdx;
        logic                   ghrRestore;
        logic                   btbWe;
        logic [`RV_BP_BITS-1:0] btbIdx;
        logic [`RV_XLEN-1:0]    target;
    } bpUpdate_t;

    typedef struct packed {
        logic                we;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
    } dmemReq_t;

endpackage

`default_nettype wire

// ==== verilog/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    // Supported major opcodes
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_LUI    = 7'b0110111
    } opcode_t;

    // funct3 codes, several share an encoding
    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;  // lw and sw
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_J, IMM_U
    } immKind_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT
    } aluOp_t;

    typedef enum logic [1:0] {
        FWD_RF, FWD_WB, FWD_MEM
    } fwdSel_t;

    typedef enum logic [1:0] {
        RES_ALU, RES_MEM, RES_PC4, RES_IMM
    } resultSel_t;

endpackage

`default_nettype wire

// ==== verilog/rvConsts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path width
`define RV_XLEN 32

// Index width shared by PHT, GHR and BTB
`define RV_BP_BITS 5

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
